/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;                 // Data word width
    localparam int FUNCT_W    = 6;                  // R-type function field
    localparam int SHAMT_W    = 5;                  // Shift amount field
    localparam int REG_ADDR_W = 5;                  // Register number

    // Function codes, also used directly as the ALU operation code
    localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;   // Shift left logical
    localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;   // Shift right logical
    localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;   // Shift right arithmetic
    localparam logic [FUNCT_W-1:0] FN_SLLV = 6'b000100;   // Variable left logical
    localparam logic [FUNCT_W-1:0] FN_SRLV = 6'b000110;   // Variable right logical
    localparam logic [FUNCT_W-1:0] FN_SRAV = 6'b000111;   // Variable right arithmetic
    localparam logic [FUNCT_W-1:0] FN_ADD  = 6'b100000;   // Signed add, traps on ovf
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;   // Wrapping add
    localparam logic [FUNCT_W-1:0] FN_SUB  = 6'b100010;   // Signed subtract
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;   // Wrapping subtract
    localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
    localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
    localparam logic [FUNCT_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [FUNCT_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;   // Signed set on less than

    typedef enum logic [3:0] {
        OPC_RTYPE = 4'd0,                           // Operation from funct field
        OPC_ADD   = 4'd1,                           // ADDI
        OPC_ADDU  = 4'd2,                           // ADDIU, load/store address
        OPC_SUB   = 4'd3,
        OPC_AND   = 4'd4,                           // ANDI
        OPC_OR    = 4'd5,                           // ORI
        OPC_XOR   = 4'd6,                           // XORI
        OPC_SLT   = 4'd7,                           // SLTI
        OPC_LUI   = 4'd8                            // Immediate into upper half
    } op_class_t;

    typedef enum logic [1:0] {
        EXT_NONE = 2'd0,                            // Register value as operand B
        EXT_SIGN = 2'd1,
        EXT_ZERO = 2'd2
    } ext_kind_t;

    typedef struct packed {
        logic [FUNCT_W-1:0] op;
        logic [SHAMT_W-1:0] shamt;
    } alu_cmd_t;

    typedef struct packed {
        logic [XLEN-1:0]       rs_val;
        logic [XLEN-1:0]       rt_val;
        logic [15:0]           imm;
        logic [SHAMT_W-1:0]    shamt;
        logic [FUNCT_W-1:0]    funct;
        op_class_t             opc;
        ext_kind_t             ext;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       store_val;       // rt_val for stores
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic                  ovf;
    } ex_mem_t;

endpackage

`default_nettype wire

/* rtl/alu_ctrl.sv */
`default_nettype none

module alu_ctrl
    (
        input  wire mips_pkg::op_class_t             i_opc,     // Class from main control
        input  wire logic [mips_pkg::FUNCT_W-1:0]    i_funct,
        input  wire logic [mips_pkg::SHAMT_W-1:0]    i_shamt,
        output mips_pkg::alu_cmd_t                   o_cmd
    );

    import mips_pkg::*;

    localparam logic [SHAMT_W-1:0] LUI_SHIFT = SHAMT_W'(16);   // Immediate to upper half

    always_comb
    begin
        o_cmd.op    = '1;                           // Undefined code, ALU gives zero
        o_cmd.shamt = '0;
        case (i_opc)
            OPC_RTYPE:
            begin
                o_cmd.op    = i_funct;
                o_cmd.shamt = i_shamt;
            end
            OPC_ADD:
            begin
                o_cmd.op = FN_ADD;                  // ADDI keeps overflow check
            end
            OPC_ADDU:
            begin
                o_cmd.op = FN_ADDU;
            end
            OPC_SUB:
            begin
                o_cmd.op = FN_SUB;
            end
            OPC_AND:
            begin
                o_cmd.op = FN_AND;
            end
            OPC_OR:
            begin
                o_cmd.op = FN_OR;
            end
            OPC_XOR:
            begin
                o_cmd.op = FN_XOR;
            end
            OPC_SLT:
            begin
                o_cmd.op = FN_SLT;
            end
            OPC_LUI:
            begin
                o_cmd.op    = FN_SLL;               // Zero-extended imm shifted up
                o_cmd.shamt = LUI_SHIFT;
            end
            default:
            begin
                o_cmd.op    = '1;
                o_cmd.shamt = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/ex_operand_sel.sv */
`default_nettype none

module ex_operand_sel
    (
        input  wire mips_pkg::ext_kind_t             i_ext,
        input  wire logic [mips_pkg::XLEN-1:0]       i_rt_val,
        input  wire logic [15:0]                     i_imm,
        output logic [mips_pkg::XLEN-1:0]            o_opnd_b
    );

    import mips_pkg::*;

    localparam int IMM_W = 16;
    localparam int PAD_W = XLEN - IMM_W;            // Bits added by extension

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] imm_zext;

    assign imm_sext = {{PAD_W{i_imm[IMM_W-1]}}, i_imm};
    assign imm_zext = {{PAD_W{1'b0}}, i_imm};

    always_comb
    begin
        case (i_ext)
            EXT_NONE: o_opnd_b = i_rt_val;          // R-type and stores
            EXT_SIGN: o_opnd_b = imm_sext;          // ADDI, ADDIU, SLTI, address
            EXT_ZERO: o_opnd_b = imm_zext;          // Logical immediates, LUI
            default:  o_opnd_b = '0;
        endcase
    end

    // Encoding 2'b11 is never produced by decode
    always_comb
    begin
        if (!$isunknown(i_ext))
        begin
            a_ext_legal: assert (i_ext inside {EXT_NONE, EXT_SIGN, EXT_ZERO})
                else $error("ex_operand_sel: illegal extension kind %0d", i_ext);
        end
    end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

module alu
    #(
        parameter int N = 32                        // Data width
    )
    (
        input  wire logic [N-1:0]          i_alu_a,
        input  wire logic [N-1:0]          i_alu_b,
        input  wire mips_pkg::alu_cmd_t    i_cmd,
        output logic [N-1:0]               o_alu_result,
        output logic                       o_ovf        // Signed overflow, ADD and SUB only
    );

    import mips_pkg::*;

    localparam int SW = $clog2(N);                  // Shift width follows data width

    logic [N-1:0]  sum;
    logic [N-1:0]  diff;
    logic [SW-1:0] var_sh;
    logic [SW-1:0] fix_sh;
    logic          add_ovf;
    logic          sub_ovf;
    logic          lt;

    assign sum    = i_alu_a + i_alu_b;
    assign diff   = i_alu_a - i_alu_b;
    assign var_sh = i_alu_a[SW-1:0];                // Low bits of rs only
    assign fix_sh = SW'(i_cmd.shamt);
    assign lt     = $signed(i_alu_a) < $signed(i_alu_b);

    // Same-sign operands giving a result of the other sign
    assign add_ovf = (i_alu_a[N-1] == i_alu_b[N-1]) && (sum[N-1] != i_alu_a[N-1]);

    // Opposite-sign operands, result sign differs from A
    assign sub_ovf = (i_alu_a[N-1] != i_alu_b[N-1]) && (diff[N-1] != i_alu_a[N-1]);

    always_comb
    begin
        case (i_cmd.op)
            FN_ADD:  o_alu_result = sum;
            FN_ADDU: o_alu_result = sum;
            FN_SUB:  o_alu_result = diff;
            FN_SUBU: o_alu_result = diff;
            FN_AND:  o_alu_result = i_alu_a & i_alu_b;
            FN_OR:   o_alu_result = i_alu_a | i_alu_b;
            FN_XOR:  o_alu_result = i_alu_a ^ i_alu_b;
            FN_NOR:  o_alu_result = ~(i_alu_a | i_alu_b);
            FN_SLL:  o_alu_result = i_alu_b << fix_sh;
            FN_SRL:  o_alu_result = i_alu_b >> fix_sh;
            FN_SRA:  o_alu_result = N'($signed(i_alu_b) >>> fix_sh);   // Sign fill
            FN_SLLV: o_alu_result = i_alu_b << var_sh;
            FN_SRLV: o_alu_result = i_alu_b >> var_sh;
            FN_SRAV: o_alu_result = N'($signed(i_alu_b) >>> var_sh);
            FN_SLT:  o_alu_result = {{(N-1){1'b0}}, lt};
            default: o_alu_result = '0;             // Undefined code
        endcase
    end

    always_comb
    begin
        case (i_cmd.op)
            FN_ADD:  o_ovf = add_ovf;
            FN_SUB:  o_ovf = sub_ovf;
            default: o_ovf = 1'b0;                  // Unsigned forms wrap silently
        endcase
    end

endmodule

`default_nettype wire

/* rtl/ex_stage.sv */
`default_nettype none

module ex_stage
    (
        input  wire logic               i_clk,
        input  wire logic               i_rst_n,
        input  wire logic               i_valid,    // One-cycle strobe from decode
        input  wire mips_pkg::id_ex_t   i_id_ex,
        output logic                    o_valid,
        output mips_pkg::ex_mem_t       o_ex_mem
    );

    import mips_pkg::*;

    alu_cmd_t        alu_cmd;
    logic [XLEN-1:0] opnd_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_ovf;
    ex_mem_t         ex_mem_d;

    alu_ctrl u_alu_ctrl
    (
        .i_opc   (i_id_ex.opc),
        .i_funct (i_id_ex.funct),
        .i_shamt (i_id_ex.shamt),
        .o_cmd   (alu_cmd)
    );

    ex_operand_sel u_operand_sel
    (
        .i_ext    (i_id_ex.ext),
        .i_rt_val (i_id_ex.rt_val),
        .i_imm    (i_id_ex.imm),
        .o_opnd_b (opnd_b)
    );

    alu #(.N(XLEN)) u_alu
    (
        .i_alu_a      (i_id_ex.rs_val),             // Operand A straight from rs
        .i_alu_b      (opnd_b),
        .i_cmd        (alu_cmd),
        .o_alu_result (alu_result),
        .o_ovf        (alu_ovf)
    );

    always_comb
    begin
        ex_mem_d.result    = alu_result;
        ex_mem_d.store_val = i_id_ex.rt_val;
        ex_mem_d.rd        = i_id_ex.rd;
        ex_mem_d.reg_write = i_id_ex.reg_write & ~alu_ovf;   // Overflow cancels writeback
        ex_mem_d.ovf       = alu_ovf;
    end

    // EX/MEM register, holds between strobes
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid  <= 1'b0;
            o_ex_mem <= '0;
        end
        else
        begin
            o_valid <= i_valid;
            if (i_valid)
            begin
                o_ex_mem <= ex_mem_d;
            end
        end
    end

    a_no_spurious_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !i_valid |=> !o_valid
    ) else $error("ex_stage: o_valid without a strobe one cycle earlier");

    a_input_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_valid |-> !$isunknown(i_id_ex)
    ) else $error("ex_stage: unknown decode bundle on a strobe");

endmodule

`default_nettype wire

/* include/ex_ref_model.svh */
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Expected ALU behavior, worked out on exact 64-bit values
function automatic logic [32:0] ref_alu(input logic [5:0] op, input logic [4:0] sh,
                                        input logic [31:0] a, input logic [31:0] b);
    longint      sum;
    longint      dif;
    logic [31:0] r;
    logic [4:0]  n;
    logic        v;
    sum = longint'($signed(a)) + longint'($signed(b));
    dif = longint'($signed(a)) - longint'($signed(b));
    n   = (op == FN_SLLV || op == FN_SRLV || op == FN_SRAV) ? a[4:0] : sh;   // Low 5 bits of rs
    case (op)
        FN_ADD, FN_ADDU:  r = sum[31:0];
        FN_SUB, FN_SUBU:  r = dif[31:0];
        FN_AND:           r = a & b;
        FN_OR:            r = a | b;
        FN_XOR:           r = a ^ b;
        FN_NOR:           r = ~(a | b);
        FN_SLT:           r = (dif < 0) ? 32'd1 : 32'd0;    // Exact signed compare
        FN_SLL, FN_SLLV:  r = b << n;
        FN_SRL, FN_SRLV:  r = b >> n;
        FN_SRA, FN_SRAV:  r = (b >> n) | (b[31] ? ~(32'hffff_ffff >> n) : 32'h0);
        default:          r = 32'h0;                        // Undefined code
    endcase
    // Overflow when the wrapped word differs from the exact value
    case (op)
        FN_ADD:  v = (sum != longint'($signed(r)));
        FN_SUB:  v = (dif != longint'($signed(r)));
        default: v = 1'b0;
    endcase
    return {v, r};
endfunction

function automatic ex_mem_t ref_ex_mem(input id_ex_t b);
    ex_mem_t     e;
    logic [31:0] opnd;
    logic [5:0]  op;
    logic [4:0]  sh;
    logic [32:0] res;
    case (b.ext)
        EXT_SIGN: opnd = 32'($signed(b.imm));
        EXT_ZERO: opnd = 32'(b.imm);
        default:  opnd = b.rt_val;
    endcase
    sh = 5'd0;
    case (b.opc)
        OPC_RTYPE:
        begin
            op = b.funct;
            sh = b.shamt;
        end
        OPC_ADD:  op = FN_ADD;
        OPC_ADDU: op = FN_ADDU;
        OPC_SUB:  op = FN_SUB;
        OPC_AND:  op = FN_AND;
        OPC_OR:   op = FN_OR;
        OPC_XOR:  op = FN_XOR;
        OPC_SLT:  op = FN_SLT;
        OPC_LUI:
        begin
            op = FN_SLL;                            // Immediate into upper half
            sh = 5'd16;
        end
        default:  op = 6'h3f;
    endcase
    res         = ref_alu(op, sh, b.rs_val, opnd);
    e.result    = res[31:0];
    e.store_val = b.rt_val;
    e.rd        = b.rd;
    e.ovf       = res[32];
    e.reg_write = b.reg_write & ~res[32];
    return e;
endfunction

`endif

/* tests/tb_ex_stage.sv */
`default_nettype none

module tb_ex_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int MAX_WAIT = 20;                   // Cycles allowed for o_valid
    localparam int BURST    = 8;
    localparam logic [5:0] RFNS [0:8] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
                                          FN_OR, FN_XOR, FN_NOR, FN_SLT};

    logic    clk = 1'b0;
    logic    rst_n;
    logic    valid;
    id_ex_t  id_ex;
    logic    out_valid;
    ex_mem_t ex_mem;
    int      seed = 32'h43f4_36a3;
    int      errors;
    int      errors_seen;
    int      checks;
    int      tests;

    `include "ex_ref_model.svh"

    ex_stage dut
    (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_valid  (valid),
        .i_id_ex  (id_ex),
        .o_valid  (out_valid),
        .o_ex_mem (ex_mem)
    );

    always
    begin
        #4 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic id_ex_t make_r(input logic [5:0] fn, input logic [31:0] rs,
                                      input logic [31:0] rt, input logic [4:0] sh);
        id_ex_t b;
        b           = '0;
        b.rs_val    = rs;
        b.rt_val    = rt;
        b.shamt     = sh;
        b.funct     = fn;
        b.opc       = OPC_RTYPE;
        b.ext       = EXT_NONE;
        b.rd        = 5'(rand32());
        b.reg_write = 1'b1;
        return b;
    endfunction

    // Funct and shamt get junk, the class must override them
    function automatic id_ex_t make_i(input op_class_t opc, input ext_kind_t ext,
                                      input logic [31:0] rs, input logic [15:0] imm);
        id_ex_t b;
        b     = make_r(6'(rand32()), rs, rand32(), 5'(rand32()));
        b.imm = imm;
        b.opc = opc;
        b.ext = ext;
        return b;
    endfunction

    task automatic check(input string msg, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s: got %h, expected %h", $time, msg,
                     actual, expected);
        end
    endtask

    task automatic check_output(input string name, input ex_mem_t exp);
        check({name, " result"}, ex_mem.result, exp.result);
        check({name, " store_val"}, ex_mem.store_val, exp.store_val);
        check({name, " rd/reg_write/ovf"}, 32'({ex_mem.rd, ex_mem.reg_write, ex_mem.ovf}),
              32'({exp.rd, exp.reg_write, exp.ovf}));
    endtask

    task automatic wait_for_valid(output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < MAX_WAIT)
        begin
            @(negedge clk);
            cycles++;
            seen = out_valid;
        end
        if (!seen)
        begin
            errors++;
            $display("Timeout at %0t: o_valid did not rise in %0d cycles", $time, MAX_WAIT);
        end
    endtask

    // One strobe, then the response one cycle later
    task automatic run_one(input string name, input id_ex_t b);
        int cycles;
        @(posedge clk);
        valid <= 1'b1;
        id_ex <= b;
        @(posedge clk);
        valid <= 1'b0;
        wait_for_valid(cycles);
        check({name, " latency"}, cycles, 1);
        check_output(name, ref_ex_mem(b));
        @(negedge clk);
        check({name, " o_valid single cycle"}, 32'(out_valid), 0);
    endtask

    task automatic report(input string name);
        tests++;
        $display("%s: %0d errors", name, errors - errors_seen);
        errors_seen = errors;
    endtask

    task automatic test_reset();
        for (int i = 0; i < 6; i++)
        begin
            @(negedge clk);
            check("reset o_valid", 32'(out_valid), 0);
            check("reset result", ex_mem.result, 0);
            check("reset store_val", ex_mem.store_val, 0);
            check("reset flags", 32'({ex_mem.rd, ex_mem.reg_write, ex_mem.ovf}), 0);
        end
    endtask

    task automatic test_rtype();
        logic [31:0] as [0:3] = '{32'h0, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_fffe};
        logic [31:0] bs [0:3] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h3};
        for (int f = 0; f < 9; f++)
        begin
            for (int k = 0; k < 6; k++)
            begin
                run_one($sformatf("rtype %h", RFNS[f]), make_r(RFNS[f],
                        (k < 4) ? as[k] : rand32(), (k < 4) ? bs[k] : rand32(), 5'd0));
            end
        end
    endtask

    task automatic test_shifts();
        logic [5:0] fixed [0:2] = '{FN_SLL, FN_SRL, FN_SRA};
        logic [5:0] vars  [0:2] = '{FN_SLLV, FN_SRLV, FN_SRAV};
        logic [4:0] amts  [0:3] = '{5'd0, 5'd1, 5'd16, 5'd31};
        for (int f = 0; f < 3; f++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                run_one("shift fixed", make_r(fixed[f], rand32(), rand32() | 32'h8000_0000,
                        amts[k]));
                run_one("shift variable", make_r(vars[f], (rand32() & 32'hffff_ffc0) |
                        32'h40 | 32'(amts[k]), rand32(), 5'(rand32())));   // rs above 31
            end
        end
        run_one("SRA", make_r(FN_SRA, 32'h0, 32'h8000_0000, 5'd31));
        check("SRA sign fill", ex_mem.result, 32'hffff_ffff);
        run_one("SRAV", make_r(FN_SRAV, 32'h0000_0fe4, 32'h8000_0000, 5'd0));
        check("SRAV low five bits", ex_mem.result, 32'hf800_0000);
    endtask

    task automatic test_immediate();
        run_one("ADDI", make_i(OPC_ADD, EXT_SIGN, 32'd100, 16'hfff0));
        check("ADDI sign extension", ex_mem.result, 32'd84);
        run_one("ADDIU", make_i(OPC_ADDU, EXT_SIGN, rand32(), 16'h8001));
        run_one("ANDI", make_i(OPC_AND, EXT_ZERO, 32'hffff_ffff, 16'h8421));
        check("ANDI zero extension", ex_mem.result, 32'h0000_8421);
        run_one("ORI", make_i(OPC_OR, EXT_ZERO, rand32(), 16'hf00f));
        run_one("XORI", make_i(OPC_XOR, EXT_ZERO, 32'hffff_0000, 16'h8000));
        run_one("SLTI", make_i(OPC_SLT, EXT_SIGN, 32'hffff_fffb, 16'h0003));
        check("SLTI signed compare", ex_mem.result, 32'd1);
        run_one("LUI", make_i(OPC_LUI, EXT_ZERO, rand32(), 16'hbeef));
        check("LUI upper half", ex_mem.result, 32'hbeef_0000);
    endtask

    task automatic test_overflow();
        logic [31:0] oa  [0:3] = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff};
        logic [31:0] ob  [0:3] = '{32'h1, 32'h8000_0000, 32'h1, 32'hffff_ffff};
        logic [5:0]  sfn [0:3] = '{FN_ADD, FN_ADD, FN_SUB, FN_SUB};
        logic [5:0]  ufn [0:3] = '{FN_ADDU, FN_ADDU, FN_SUBU, FN_SUBU};
        for (int k = 0; k < 4; k++)
        begin
            run_one("signed overflow", make_r(sfn[k], oa[k], ob[k], 5'd0));
            check("ovf set, reg_write cleared", 32'({ex_mem.ovf, ex_mem.reg_write}), 32'b10);
            run_one("unsigned wrap", make_r(ufn[k], oa[k], ob[k], 5'd0));
            check("no ovf, reg_write kept", 32'({ex_mem.ovf, ex_mem.reg_write}), 32'b01);
        end
    endtask

    task automatic test_burst();
        id_ex_t items [0:BURST-1];
        int     cycles;
        for (int k = 0; k < BURST; k++)
        begin
            if (k % 2 == 1)
                items[k] = make_i(OPC_ADDU, EXT_SIGN, rand32(), 16'(rand32()));
            else
                items[k] = make_r(RFNS[int'(rand32() % 9)], rand32(), rand32(), 5'(rand32()));
        end
        fork
            begin
                for (int k = 0; k < BURST; k++)
                begin
                    @(posedge clk);
                    valid <= 1'b1;
                    id_ex <= items[k];
                end
                @(posedge clk);
                valid <= 1'b0;
            end
            begin
                wait_for_valid(cycles);
                check("burst first latency", cycles, 2);    // Counted from before the strobe
                for (int j = 0; j < BURST; j++)
                begin
                    check($sformatf("burst %0d o_valid", j), 32'(out_valid), 1);
                    check_output($sformatf("burst %0d", j), ref_ex_mem(items[j]));
                    @(negedge clk);
                end
                check("burst end o_valid", 32'(out_valid), 0);
            end
        join
    endtask

    initial
    begin
        valid = 1'b0;
        id_ex = '0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        report("reset state");
        test_rtype();
        report("rtype alu");
        test_shifts();
        report("shifts");
        test_immediate();
        report("immediates");
        test_overflow();
        report("overflow");
        test_burst();
        report("burst");
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
rtl/mips_pkg.sv
rtl/alu_ctrl.sv
rtl/ex_operand_sel.sv
rtl/alu.sv
rtl/ex_stage.sv
tests/tb_ex_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_ex_stage -o tb_ex_stage
out=$(./obj_dir/tb_ex_stage)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"
then
    exit 0
fi
exit 1
